// File: verilog/pit_config.svh
// Interval timer configuration
`ifndef PIT_CONFIG_SVH
`define PIT_CONFIG_SVH

// Number of counter channels
`define PIT_NUM_CHAN 3

// Down counter and count register width
`define PIT_CNT_W 16

// Bus address of the control word register
// Addresses 0 to 2 select the channel count registers
`define PIT_ADDR_CTRL 2'd3

`endif

// File: verilog/pit_pkg.sv
// Interval timer types
package pit_pkg;

  // Mode field of the control word
  // Only modes 0, 2 and 3 count, the rest leave the channel idle
  typedef enum logic [2:0] {
    MODE_TC0       = 3'd0,
    MODE_ONESHOT1  = 3'd1,
    MODE_RATE2     = 3'd2,
    MODE_SQUARE3   = 3'd3,
    MODE_SWSTROBE4 = 3'd4,
    MODE_HWSTROBE5 = 3'd5
  } pit_mode_e;

  // Read/write access field
  typedef enum logic [1:0] {
    RW_LATCH   = 2'd0,
    RW_LSB     = 2'd1,
    RW_MSB     = 2'd2,
    RW_LSB_MSB = 2'd3
  } pit_rw_e;

  // Control word as written to the control address
  typedef struct packed {
    logic [1:0] sc;
    pit_rw_e    rw;
    pit_mode_e  mode;
    // BCD select, not supported
    logic       bcd;
  } pit_ctrl_t;

endpackage

// File: verilog/pit_chan_if.sv
// Decode to channel link
`timescale 1ns/10ps
`include "pit_config.svh"

interface pit_chan_if
  import pit_pkg::*;
();

  // Pulse on a mode setting control word
  logic                  ctrl_wr;
  // Mode of the last control word, held
  pit_mode_e             mode;
  // Pulse once the last count byte is in
  logic                  count_wr;
  // Assembled count
  logic [`PIT_CNT_W-1:0] count_val;
  // Counter latch command pulse
  logic                  latch_cmd;
  // Pulse after the final byte of a read sequence
  logic                  rd_done;
  // Latched count or live count
  logic [`PIT_CNT_W-1:0] rd_val;

  modport decode (
    output ctrl_wr, mode, count_wr, count_val, latch_cmd, rd_done,
    input  rd_val
  );

  modport channel (
    input  ctrl_wr, mode, count_wr, count_val, latch_cmd, rd_done,
    output rd_val
  );

endinterface

// File: verilog/pit_bus_decode.sv
// Host bus decode stage
`timescale 1ns/10ps
`include "pit_config.svh"

module pit_bus_decode
  import pit_pkg::*;
(
  input  logic               CLK,
  input  logic               arst_n,
  input  logic               sel,
  input  logic               wr,
  input  logic               rd,
  input  logic [1:0]         addr,
  input  logic [7:0]         wdata,
  output logic [7:0]         rdata,
  pit_chan_if.decode         ch0,
  pit_chan_if.decode         ch1,
  pit_chan_if.decode         ch2
);

  localparam int NCH = `PIT_NUM_CHAN;

  pit_ctrl_t             cw;
  pit_mode_e             cw_mode;
  logic                  wr_en;
  logic                  rd_en;
  logic                  ctrl_hit;
  logic [7:0]            rd_byte;

  // Per channel state
  pit_rw_e               rw_q      [NCH];
  pit_mode_e             mode_q    [NCH];
  logic                  wr_msb    [NCH];
  logic                  rd_msb    [NCH];
  logic [7:0]            lo_byte   [NCH];
  logic [`PIT_CNT_W-1:0] count_val [NCH];
  logic [`PIT_CNT_W-1:0] rd_val    [NCH];
  logic                  ctrl_wr_q [NCH];
  logic                  count_wr_q[NCH];
  logic                  latch_q   [NCH];
  logic                  rd_done_q [NCH];

  assign cw    = pit_ctrl_t'(wdata);
  assign wr_en = sel & wr;
  assign rd_en = sel & rd;

  // sc of 3 is not a channel on this part
  assign ctrl_hit = wr_en && (addr == `PIT_ADDR_CTRL) && (cw.sc != 2'd3);

  // Modes 6 and 7 alias 2 and 3
  assign cw_mode = cw.mode[1] ? pit_mode_e'({1'b0, cw.mode[1:0]}) : cw.mode;

  // Byte of the addressed channel for this read
  always_comb
  begin
    rd_byte = 8'h00;
    for (int i = 0; i < NCH; i++)
    begin
      if (addr == 2'(i))
      begin
        case (rw_q[i])
          RW_MSB:     rd_byte = rd_val[i][15:8];
          RW_LSB_MSB: rd_byte = rd_msb[i] ? rd_val[i][15:8] : rd_val[i][7:0];
          default:    rd_byte = rd_val[i][7:0];
        endcase
      end
    end
  end

  // Control registers, byte flip-flops and strobes
  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rdata <= 8'h00;
      for (int i = 0; i < NCH; i++)
      begin
        rw_q[i]       <= RW_LSB_MSB;
        mode_q[i]     <= MODE_ONESHOT1;
        wr_msb[i]     <= 1'b0;
        rd_msb[i]     <= 1'b0;
        ctrl_wr_q[i]  <= 1'b0;
        count_wr_q[i] <= 1'b0;
        latch_q[i]    <= 1'b0;
        rd_done_q[i]  <= 1'b0;
      end
    end
    else
    begin
      // Registered read data, held between reads
      if (rd_en)
        rdata <= rd_byte;
      for (int i = 0; i < NCH; i++)
      begin
        // Strobes last one cycle
        ctrl_wr_q[i]  <= 1'b0;
        count_wr_q[i] <= 1'b0;
        latch_q[i]    <= 1'b0;
        rd_done_q[i]  <= 1'b0;
        // Control word for this channel
        if (ctrl_hit && (cw.sc == 2'(i)))
        begin
          wr_msb[i] <= 1'b0;
          rd_msb[i] <= 1'b0;
          if (cw.rw == RW_LATCH)
            latch_q[i] <= 1'b1;
          else
          begin
            rw_q[i]      <= cw.rw;
            mode_q[i]    <= cw_mode;
            ctrl_wr_q[i] <= 1'b1;
          end
        end
        // Count byte write
        if (wr_en && (addr == 2'(i)))
        begin
          if (rw_q[i] == RW_LSB_MSB)
          begin
            // MSB closes the two byte sequence
            wr_msb[i]     <= !wr_msb[i];
            count_wr_q[i] <= wr_msb[i];
          end
          else
            count_wr_q[i] <= 1'b1;
        end
        // Count byte read
        if (rd_en && (addr == 2'(i)))
        begin
          if (rw_q[i] == RW_LSB_MSB)
          begin
            rd_msb[i]    <= !rd_msb[i];
            rd_done_q[i] <= rd_msb[i];
          end
          else
            rd_done_q[i] <= 1'b1;
        end
      end
    end
  end

  // Count assembly
  always_ff @(posedge CLK)
  begin
    for (int i = 0; i < NCH; i++)
    begin
      if (wr_en && (addr == 2'(i)))
      begin
        case (rw_q[i])
          RW_LSB: count_val[i] <= {8'h00, wdata};
          RW_MSB: count_val[i] <= {wdata, 8'h00};
          RW_LSB_MSB:
          begin
            if (wr_msb[i])
              count_val[i] <= {wdata, lo_byte[i]};
            else
              lo_byte[i] <= wdata;
          end
          default: ;
        endcase
      end
    end
  end

  // Channel 0 link
  assign ch0.ctrl_wr   = ctrl_wr_q[0];
  assign ch0.mode      = mode_q[0];
  assign ch0.count_wr  = count_wr_q[0];
  assign ch0.count_val = count_val[0];
  assign ch0.latch_cmd = latch_q[0];
  assign ch0.rd_done   = rd_done_q[0];
  assign rd_val[0]     = ch0.rd_val;

  // Channel 1 link
  assign ch1.ctrl_wr   = ctrl_wr_q[1];
  assign ch1.mode      = mode_q[1];
  assign ch1.count_wr  = count_wr_q[1];
  assign ch1.count_val = count_val[1];
  assign ch1.latch_cmd = latch_q[1];
  assign ch1.rd_done   = rd_done_q[1];
  assign rd_val[1]     = ch1.rd_val;

  // Channel 2 link
  assign ch2.ctrl_wr   = ctrl_wr_q[2];
  assign ch2.mode      = mode_q[2];
  assign ch2.count_wr  = count_wr_q[2];
  assign ch2.count_val = count_val[2];
  assign ch2.latch_cmd = latch_q[2];
  assign ch2.rd_done   = rd_done_q[2];
  assign rd_val[2]     = ch2.rd_val;

endmodule

// File: verilog/pit_channel.sv
// Timer counter channel
`timescale 1ns/10ps
`include "pit_config.svh"

module pit_channel
  import pit_pkg::*;
(
  input  logic         CLK,
  input  logic         arst_n,
  input  logic         cnt_step,
  input  logic         gate,
  output logic         out,
  pit_chan_if.channel  bus
);

  localparam int W = `PIT_CNT_W;
  localparam logic [W-1:0] ONE = W'(1);
  localparam logic [W-1:0] TWO = W'(2);

  // Count register and down counter
  logic [W-1:0] cnt_reg;
  logic [W-1:0] cnt;
  logic [W-1:0] cnt_m1;
  logic [W-1:0] cnt_m2;
  // Even reload value for square wave
  logic [W-1:0] sq_init;
  logic [W-1:0] latch_val;

  logic load_pend;
  logic running;
  logic reload_req;
  // Extra high step for odd square wave counts
  logic odd_hold;
  logic latch_held;

  logic cnt_mode;
  logic step;
  logic gate_block;
  logic start;

  // Modes 0, 2 and 3 count, all others are idle
  assign cnt_mode = (bus.mode == MODE_TC0) || (bus.mode == MODE_RATE2) ||
                    (bus.mode == MODE_SQUARE3);

  // Gated count step
  assign step = cnt_step & gate;

  // Gate low halts and holds OUT high in modes 2 and 3
  assign gate_block = !gate && ((bus.mode == MODE_RATE2) || (bus.mode == MODE_SQUARE3));

  assign cnt_m1  = cnt - ONE;
  assign cnt_m2  = cnt - TWO;
  assign sq_init = {cnt_reg[W-1:1], 1'b0};

  // Initial load or restart after gate low
  assign start = (load_pend && cnt_step) || (running && reload_req && step);

  // Count register follows every count write
  always_ff @(posedge CLK)
  begin
    if (bus.count_wr)
      cnt_reg <= bus.count_val;
  end

  // Output latch capture
  always_ff @(posedge CLK)
  begin
    if (bus.latch_cmd && !latch_held)
      latch_val <= cnt;
  end

  // Latch held until the read sequence completes
  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
      latch_held <= 1'b0;
    else if (bus.rd_done)
      latch_held <= 1'b0;
    else if (bus.latch_cmd)
      latch_held <= 1'b1;
  end

  // Down counter and OUT control
  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      load_pend  <= 1'b0;
      running    <= 1'b0;
      reload_req <= 1'b0;
      odd_hold   <= 1'b0;
      cnt        <= '0;
      out        <= 1'b1;
    end
    else if (bus.ctrl_wr)
    begin
      // New mode stops the channel until a count arrives
      load_pend  <= 1'b0;
      running    <= 1'b0;
      reload_req <= 1'b0;
      odd_hold   <= 1'b0;
      out        <= (bus.mode != MODE_TC0);
    end
    else
    begin
      if (start)
      begin
        // This step loads and does not count
        running    <= 1'b1;
        load_pend  <= 1'b0;
        reload_req <= 1'b0;
        out        <= (bus.mode != MODE_TC0);
        if (bus.mode == MODE_SQUARE3)
        begin
          cnt      <= sq_init;
          odd_hold <= cnt_reg[0];
        end
        else
          cnt <= cnt_reg;
      end
      else if (running && gate_block)
      begin
        out        <= 1'b1;
        reload_req <= 1'b1;
      end
      else if (running && step)
      begin
        case (bus.mode)
          MODE_TC0:
          begin
            // Terminal count sets OUT, counter wraps on
            cnt <= cnt_m1;
            if (cnt_m1 == '0)
              out <= 1'b1;
          end
          MODE_RATE2:
          begin
            if (cnt == ONE)
            begin
              // Low pulse over, reload
              cnt <= cnt_reg;
              out <= 1'b1;
            end
            else
            begin
              cnt <= cnt_m1;
              if (cnt_m1 == ONE)
                out <= 1'b0;
            end
          end
          MODE_SQUARE3:
          begin
            if (odd_hold)
              odd_hold <= 1'b0;
            else if (cnt == TWO)
            begin
              // Half period done
              cnt      <= sq_init;
              out      <= !out;
              // Odd N gives the high half one more step
              odd_hold <= cnt_reg[0] & !out;
            end
            else
              cnt <= cnt_m2;
          end
          default: ;
        endcase
      end
      // Mode 0 reloads on a new count, modes 2 and 3 wait for reload
      if (bus.count_wr && cnt_mode && (!running || (bus.mode == MODE_TC0)))
        load_pend <= 1'b1;
    end
  end

  // Read back latched value while held
  assign bus.rd_val = latch_held ? latch_val : cnt;

endmodule

// File: verilog/pit_top.sv
// Interval timer top level
`timescale 1ns/10ps
`include "pit_config.svh"

module pit_top
(
  input  logic                     CLK,
  input  logic                     arst_n,
  input  logic                     sel,
  input  logic                     wr,
  input  logic                     rd,
  input  logic [1:0]               addr,
  input  logic [7:0]               wdata,
  output logic [7:0]               rdata,
  input  logic [`PIT_NUM_CHAN-1:0] cnt_step,
  input  logic [`PIT_NUM_CHAN-1:0] gate,
  output logic [`PIT_NUM_CHAN-1:0] out
);

  // One link per channel
  pit_chan_if chan0_if ();
  pit_chan_if chan1_if ();
  pit_chan_if chan2_if ();

  // Bus decode and read byte select
  pit_bus_decode decode_inst (
    .CLK    (CLK),
    .arst_n (arst_n),
    .sel    (sel),
    .wr     (wr),
    .rd     (rd),
    .addr   (addr),
    .wdata  (wdata),
    .rdata  (rdata),
    .ch0    (chan0_if.decode),
    .ch1    (chan1_if.decode),
    .ch2    (chan2_if.decode)
  );

  // Counter channels
  pit_channel chan0_inst (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .cnt_step (cnt_step[0]),
    .gate     (gate[0]),
    .out      (out[0]),
    .bus      (chan0_if.channel)
  );

  pit_channel chan1_inst (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .cnt_step (cnt_step[1]),
    .gate     (gate[1]),
    .out      (out[1]),
    .bus      (chan1_if.channel)
  );

  pit_channel chan2_inst (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .cnt_step (cnt_step[2]),
    .gate     (gate[2]),
    .out      (out[2]),
    .bus      (chan2_if.channel)
  );

endmodule

// File: sim/pit_tb.sv
// Interval timer testbench
`timescale 1ns/10ps
`include "pit_config.svh"

module pit_tb
  import pit_pkg::*;
();

  localparam int NROWS = 12;
  localparam int NCH   = `PIT_NUM_CHAN;

  // One stimulus row, gate low over steps gs to gs+gl-1
  typedef struct {
    string     name;
    int        ch;
    pit_mode_e mode;
    pit_rw_e   rw;
    int        n;
    int        steps;
    int        gs;
    int        gl;
    int        latch_at;
    bit        rnd;
  } row_t;

  logic           CLK;
  logic           arst_n;
  logic           sel;
  logic           wr;
  logic           rd;
  logic [1:0]     addr;
  logic [7:0]     wdata;
  logic [7:0]     rdata;
  logic [NCH-1:0] cnt_step;
  logic [NCH-1:0] gate;
  logic [NCH-1:0] out;

  row_t rows [NROWS];
  int   seed;
  int   row_errs;
  int   total_errs;
  int   rows_passed;
  int   rows_failed;
  int   r;
  bit   timed_out;

  pit_top pit_top_inst (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .sel      (sel),
    .wr       (wr),
    .rd       (rd),
    .addr     (addr),
    .wdata    (wdata),
    .rdata    (rdata),
    .cnt_step (cnt_step),
    .gate     (gate),
    .out      (out)
  );

  // 100 ns clock
  initial
  begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // OUT from the mode rules, k counts steps since the last load
  function bit expected_out(input pit_mode_e mode, input int n, input int k, input bit g);
    int ph;
    ph = k % n;
    case (mode)
      MODE_TC0:   expected_out = (k >= n);
      MODE_RATE2: expected_out = !g || (ph != n - 1);
      default:    expected_out = !g || (ph < (n + 1) / 2);
    endcase
  endfunction

  // Rate generator count after k steps
  function int expected_count(input int n, input int k);
    expected_count = n - (k % n);
  endfunction

  task bus_write(input logic [1:0] a, input logic [7:0] d);
  begin
    @(posedge CLK);
    sel   <= 1'b1;
    wr    <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge CLK);
    sel <= 1'b0;
    wr  <= 1'b0;
  end
  endtask

  // rdata is valid one cycle after the strobe
  task bus_read(input logic [1:0] a, output logic [7:0] d);
  begin
    @(posedge CLK);
    sel  <= 1'b1;
    rd   <= 1'b1;
    addr <= a;
    @(posedge CLK);
    sel <= 1'b0;
    rd  <= 1'b0;
    @(negedge CLK);
    d = rdata;
  end
  endtask

  task write_ctrl(input int ch, input pit_mode_e mode, input pit_rw_e rw_mode);
    pit_ctrl_t cw;
  begin
    cw.sc   = 2'(ch);
    cw.rw   = rw_mode;
    cw.mode = mode;
    cw.bcd  = 1'b0;
    bus_write(`PIT_ADDR_CTRL, cw);
  end
  endtask

  // Bytes as the access field asks
  task write_count(input int ch, input pit_rw_e rw_mode, input logic [15:0] n);
  begin
    case (rw_mode)
      RW_LSB: bus_write(2'(ch), n[7:0]);
      RW_MSB: bus_write(2'(ch), n[15:8]);
      default:
      begin
        bus_write(2'(ch), n[7:0]);
        bus_write(2'(ch), n[15:8]);
      end
    endcase
  end
  endtask

  // Wait for OUT to settle after a control word
  task wait_out(input int ch, input bit level, input int limit);
    int cyc;
  begin
    cyc = 0;
    while ((out[ch] !== level) && (cyc < limit))
    begin
      @(negedge CLK);
      cyc++;
    end
    if (out[ch] !== level)
    begin
      $display("Timeout: OUT of channel %0d never went to %0b after the control word",
               ch, level);
      timed_out = 1'b1;
    end
  end
  endtask

  // One count step every fourth cycle, OUT sampled at the end
  task do_step(input int ch, input bit g, output logic o);
  begin
    @(posedge CLK);
    gate[ch]     <= g;
    cnt_step[ch] <= 1'b1;
    @(posedge CLK);
    cnt_step[ch] <= 1'b0;
    @(posedge CLK);
    @(posedge CLK);
    @(negedge CLK);
    o = out[ch];
  end
  endtask

  task check_byte(input string what, input logic [7:0] got, input logic [7:0] exp_b);
  begin
    if (got !== exp_b)
    begin
      $display("[FAIL] %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp_b);
      row_errs++;
    end
  end
  endtask

  task run_row(input int idx);
    row_t       row;
    int         n;
    int         k;
    int         i;
    int         lat;
    int         rv;
    bit         g;
    bit         restart;
    bit         exp_o;
    logic       o;
    logic [7:0] b;
  begin
    row      = rows[idx];
    n        = row.n;
    row_errs = 0;
    lat      = 0;
    if (row.rnd)
    begin
      rv = $random(seed);
      n  = 3 + (rv & 15);
    end
    write_ctrl(row.ch, row.mode, row.rw);
    wait_out(row.ch, row.mode != MODE_TC0, 20);
    if (!timed_out)
    begin
      write_count(row.ch, row.rw, 16'(n));
      // count_wr, then the pending load
      repeat (2) @(posedge CLK);
      k       = 0;
      restart = 1'b0;
      for (i = 0; i < row.steps; i++)
      begin
        g = !((row.gl > 0) && (i >= row.gs) && (i < row.gs + row.gl));
        do_step(row.ch, g, o);
        // Step 0 is the load step
        if (i == 0)
          k = 0;
        else if (row.mode == MODE_TC0)
        begin
          if (g)
            k++;
        end
        else if (!g)
          restart = 1'b1;
        else if (restart)
        begin
          k       = 0;
          restart = 1'b0;
        end
        else
          k++;
        exp_o = expected_out(row.mode, n, k, g);
        if (o !== exp_o)
        begin
          $display("[FAIL] %0t: row %0d step %0d OUT %0b, expected %0b",
                   $time, idx, i, o, exp_o);
          row_errs++;
        end
        // Latch, then read LSB now and MSB after the next step
        if ((row.latch_at > 0) && (i == row.latch_at))
        begin
          write_ctrl(row.ch, MODE_TC0, RW_LATCH);
          lat = expected_count(n, k);
          bus_read(2'(row.ch), b);
          check_byte("latched LSB", b, lat[7:0]);
        end
        if ((row.latch_at > 0) && (i == row.latch_at + 1))
        begin
          bus_read(2'(row.ch), b);
          check_byte("latched MSB", b, lat[15:8]);
          // Latch released, live count from here
          lat = expected_count(n, k);
          bus_read(2'(row.ch), b);
          check_byte("live LSB", b, lat[7:0]);
          bus_read(2'(row.ch), b);
          check_byte("live MSB", b, lat[15:8]);
        end
      end
    end
    if ((row_errs == 0) && !timed_out)
    begin
      $display("Row %0d %s (N=%0d): PASS", idx, row.name, n);
      rows_passed++;
    end
    else
    begin
      $display("Row %0d %s (N=%0d): FAIL", idx, row.name, n);
      rows_failed++;
    end
    total_errs += row_errs;
  end
  endtask

  initial
  begin
    seed        = 32'h4fc1_cb40;
    total_errs  = 0;
    rows_passed = 0;
    rows_failed = 0;
    timed_out   = 1'b0;
    arst_n      = 1'b0;
    sel         = 1'b0;
    wr          = 1'b0;
    rd          = 1'b0;
    addr        = 2'd0;
    wdata       = 8'h00;
    cnt_step    = '0;
    gate        = '1;

    // name, ch, mode, rw, N, steps, gate start, gate len, latch step, random
    // Latch row count crosses 0x0100 between the two reads
    rows[0]  = '{"Mode 0 count", 0, MODE_TC0, RW_LSB_MSB, 5, 8, 0, 0, 0, 1'b0};
    rows[1]  = '{"Mode 2 rate", 1, MODE_RATE2, RW_LSB_MSB, 4, 13, 0, 0, 0, 1'b0};
    rows[2]  = '{"Mode 3 even", 2, MODE_SQUARE3, RW_LSB_MSB, 6, 13, 0, 0, 0, 1'b0};
    rows[3]  = '{"Mode 3 odd", 2, MODE_SQUARE3, RW_LSB_MSB, 7, 15, 0, 0, 0, 1'b0};
    rows[4]  = '{"Latch readback", 1, MODE_RATE2, RW_LSB_MSB, 261, 8, 0, 0, 5, 1'b0};
    rows[5]  = '{"Mode 0 gate", 0, MODE_TC0, RW_LSB_MSB, 5, 11, 2, 3, 0, 1'b0};
    rows[6]  = '{"Mode 2 gate", 1, MODE_RATE2, RW_LSB_MSB, 5, 15, 3, 2, 0, 1'b0};
    // Gate drops while OUT is low
    rows[7]  = '{"Mode 2 gate force", 0, MODE_RATE2, RW_LSB_MSB, 5, 12, 5, 2, 0, 1'b0};
    rows[8]  = '{"LSB access", 2, MODE_RATE2, RW_LSB, 5, 11, 0, 0, 0, 1'b0};
    rows[9]  = '{"MSB access", 0, MODE_RATE2, RW_MSB, 256, 520, 0, 0, 0, 1'b0};
    rows[10] = '{"Random counts", 1, MODE_RATE2, RW_LSB_MSB, 0, 40, 0, 0, 0, 1'b1};
    rows[11] = '{"Random counts", 2, MODE_RATE2, RW_LSB_MSB, 0, 40, 0, 0, 0, 1'b1};

    repeat (5) @(posedge CLK);
    arst_n <= 1'b1;
    @(negedge CLK);
    if ((out !== 3'b111) || (rdata !== 8'h00))
    begin
      $display("[FAIL] %0t: after reset out=%b rdata=0x%02h", $time, out, rdata);
      total_errs++;
    end

    for (r = 0; (r < NROWS) && !timed_out; r++)
      run_row(r);

    $display("Rows passed: %0d, rows failed: %0d, check errors: %0d",
             rows_passed, rows_failed, total_errs);
    if ((total_errs == 0) && (rows_failed == 0) && !timed_out)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+verilog
verilog/pit_pkg.sv
verilog/pit_chan_if.sv
verilog/pit_bus_decode.sv
verilog/pit_channel.sv
verilog/pit_top.sv
sim/pit_tb.sv
